// File: design/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // page geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int word_width     = 16;
    localparam int page_words     = 8;
    localparam int word_idx_width = 3;
    localparam int bit_idx_width  = 4;
    localparam int code_width     = 8;
    localparam int status_width   = 2;

    localparam logic [word_idx_width-1:0] last_word = word_idx_width'(page_words - 1);

    ////////////////////////////////////////////////////////////////////////////
    // code layout
    ////////////////////////////////////////////////////////////////////////////
    localparam int word_par_lsb = 0;
    localparam int bit_par_lsb  = word_par_lsb + word_idx_width;
    localparam int overall_bit  = bit_par_lsb + bit_idx_width;

    // page status
    localparam logic [status_width-1:0] status_clean         = 2'd0;
    localparam logic [status_width-1:0] status_corrected     = 2'd1;
    localparam logic [status_width-1:0] status_uncorrectable = 2'd2;

    // contribution of one word at position idx to the page code
    function automatic logic [code_width-1:0] code_fold(
        input logic [word_width-1:0]     w,
        input logic [word_idx_width-1:0] idx
    );
        logic                  p;
        logic [code_width-1:0] c;
        p = ^w;
        c = '0;
        for (int k = 0; k < word_idx_width; k++) begin
            c[word_par_lsb + k] = idx[k] & p;
        end
        for (int b = 0; b < word_width; b++) begin
            for (int j = 0; j < bit_idx_width; j++) begin
                if (b[j]) begin
                    c[bit_par_lsb + j] = c[bit_par_lsb + j] ^ w[b];
                end
            end
        end
        c[overall_bit] = p;
        return c;
    endfunction

endpackage

`default_nettype wire

// File: design/page_decoder.sv
`default_nettype none

module page_decoder (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               full,
    output logic                               rd_req,
    input  logic                               rd_ack,
    output logic [ecc_pkg::word_idx_width-1:0] rd_addr,
    output logic                               rd_free,
    input  logic [ecc_pkg::word_width-1:0]     rd_data,
    input  logic [ecc_pkg::code_width-1:0]     rd_code,
    output logic                               out_req,
    input  logic                               out_ack,
    output logic [ecc_pkg::word_width-1:0]     out_data,
    output logic [ecc_pkg::word_idx_width-1:0] out_index,
    output logic [ecc_pkg::status_width-1:0]   out_status
);

    import ecc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_P1_RD,
        S_P1_WAIT,
        S_P2_RD,
        S_OUT,
        S_OUT_WAIT
    } state_t;

    state_t                  state;
    logic [code_width-1:0]   acc;
    logic [code_width-1:0]   syndrome;
    logic [code_width-1:0]   syn_next;
    logic [status_width-1:0] status_next;
    logic [word_width-1:0]   fix_mask;

    always_comb begin
        syn_next = acc ^ rd_code;
        if (syn_next == '0) begin
            status_next = status_clean;
        end else if (syn_next[overall_bit]) begin
            status_next = status_corrected;
        end else begin
            status_next = status_uncorrectable;
        end
    end

    // syndrome points straight at the flipped bit
    always_comb begin
        fix_mask = '0;
        if (out_status == status_corrected &&
            rd_addr == syndrome[word_par_lsb +: word_idx_width]) begin
            fix_mask[syndrome[bit_par_lsb +: bit_idx_width]] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // two pass FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            rd_req     <= 1'b0;
            rd_addr    <= '0;
            rd_free    <= 1'b0;
            out_req    <= 1'b0;
            out_index  <= last_word;
            out_status <= status_clean;
            acc        <= '0;
            syndrome   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (full && !rd_ack) begin
                        rd_req  <= 1'b1;
                        rd_addr <= '0;
                        rd_free <= 1'b0;
                        acc     <= '0;
                        state   <= S_P1_RD;
                    end
                end
                // pass 1: rebuild the code
                S_P1_RD: begin
                    if (rd_ack) begin
                        rd_req <= 1'b0;
                        acc    <= acc ^ code_fold(rd_data, rd_addr);
                        state  <= S_P1_WAIT;
                    end
                end
                S_P1_WAIT: begin
                    if (!rd_ack) begin
                        rd_req <= 1'b1;
                        if (rd_addr == last_word) begin
                            syndrome   <= syn_next;
                            out_status <= status_next;
                            rd_addr    <= '0;
                            state      <= S_P2_RD;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state   <= S_P1_RD;
                        end
                    end
                end
                // pass 2: correct and stream out
                S_P2_RD: begin
                    if (rd_ack) begin
                        rd_req    <= 1'b0;
                        out_req   <= 1'b1;
                        out_index <= rd_addr;
                        state     <= S_OUT;
                    end
                end
                S_OUT: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= S_OUT_WAIT;
                    end
                end
                S_OUT_WAIT: begin
                    if (!out_ack && !rd_ack) begin
                        if (rd_addr == last_word) begin
                            rd_free <= 1'b0;
                            state   <= S_IDLE;
                        end else begin
                            rd_req  <= 1'b1;
                            rd_addr <= rd_addr + 1'b1;
                            rd_free <= (rd_addr == last_word - 1'b1);
                            state   <= S_P2_RD;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_P2_RD && rd_ack) begin
            out_data <= rd_data ^ fix_mask;
        end
    end

    a_out_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_data)
    );

    // index wraps from the last word of one page to word 0 of the next
    a_out_index_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> out_index == word_idx_width'($past(out_index) + 1'b1)
    );

endmodule

`default_nettype wire

// File: design/page_encoder.sv
`default_nettype none

module page_encoder (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_req,
    output logic                               wr_ack,
    input  logic [ecc_pkg::word_width-1:0]     wr_data,
    input  logic                               full,
    output logic                               st_req,
    input  logic                               st_ack,
    output logic [ecc_pkg::word_idx_width-1:0] st_addr,
    output logic [ecc_pkg::word_width-1:0]     st_data,
    output logic [ecc_pkg::code_width-1:0]     st_code,
    output logic                               st_last
);

    import ecc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_STORE,
        S_ACK
    } state_t;

    state_t                    state;
    logic [word_idx_width-1:0] count;
    logic [code_width-1:0]     code_acc;
    logic                      launch;

    // a new page may only begin once the store has been drained
    assign launch = (state == S_IDLE) && wr_req && !full && !st_ack;

    ////////////////////////////////////////////////////////////////////////////
    // handshake sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            st_req   <= 1'b0;
            wr_ack   <= 1'b0;
            count    <= '0;
            code_acc <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (launch) begin
                        st_req <= 1'b1;
                        state  <= S_STORE;
                    end
                end
                S_STORE: begin
                    if (st_ack) begin
                        st_req   <= 1'b0;
                        wr_ack   <= 1'b1;
                        count    <= count + 1'b1;
                        // st_code already holds the code up to this word
                        code_acc <= st_last ? '0 : st_code;
                        state    <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!wr_req) begin
                        wr_ack <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word and running code held for the store
    always_ff @(posedge clk) begin
        if (launch) begin
            st_addr <= count;
            st_data <= wr_data;
            st_code <= code_acc ^ code_fold(wr_data, count);
            st_last <= (count == last_word);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_st_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        st_req && $past(st_req) |-> $stable(st_data)
    );

    // host ack follows the store ack of the word just counted
    a_wr_ack_after_store: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wr_ack) |-> $past(st_req && st_ack) && count == word_idx_width'(st_addr + 1'b1)
    );

endmodule

`default_nettype wire

// File: design/page_store.sv
`default_nettype none

module page_store (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               st_req,
    output logic                               st_ack,
    input  logic [ecc_pkg::word_idx_width-1:0] st_addr,
    input  logic [ecc_pkg::word_width-1:0]     st_data,
    input  logic [ecc_pkg::code_width-1:0]     st_code,
    input  logic                               st_last,
    input  logic                               rd_req,
    output logic                               rd_ack,
    input  logic [ecc_pkg::word_idx_width-1:0] rd_addr,
    input  logic                               rd_free,
    output logic [ecc_pkg::word_width-1:0]     rd_data,
    output logic [ecc_pkg::code_width-1:0]     rd_code,
    input  logic                               inj_req,
    output logic                               inj_ack,
    input  logic [ecc_pkg::word_idx_width-1:0] inj_word,
    input  logic [ecc_pkg::bit_idx_width-1:0]  inj_bit,
    output logic                               full
);

    import ecc_pkg::*;

    logic [word_width-1:0] mem [page_words];
    logic [code_width-1:0] code_mem;
    logic                  wr_take;
    logic                  rd_take;
    logic                  inj_take;

    // one cycle after req is seen, each port takes its request
    assign wr_take  = st_req && !st_ack && !full;
    assign rd_take  = rd_req && !rd_ack && full;
    assign inj_take = inj_req && !inj_ack;

    ////////////////////////////////////////////////////////////////////////////
    // acks and full flag
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_ack  <= 1'b0;
            rd_ack  <= 1'b0;
            inj_ack <= 1'b0;
            full    <= 1'b0;
        end else begin
            if (wr_take) begin
                st_ack <= 1'b1;
                if (st_last) begin
                    full <= 1'b1;
                end
            end else if (st_ack && !st_req) begin
                st_ack <= 1'b0;
            end

            if (rd_take) begin
                rd_ack <= 1'b1;
                if (rd_free) begin
                    full <= 1'b0;
                end
            end else if (rd_ack && !rd_req) begin
                rd_ack <= 1'b0;
            end

            if (inj_take) begin
                inj_ack <= 1'b1;
            end else if (inj_ack && !inj_req) begin
                inj_ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////
    // writes need full low, injection needs full high, so they never collide
    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[st_addr] <= st_data;
            if (st_last) begin
                code_mem <= st_code;
            end
        end else if (inj_take && full) begin
            mem[inj_word][inj_bit] <= ~mem[inj_word][inj_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rd_data <= mem[rd_addr];
            rd_code <= code_mem;
        end
    end

    // a pending request on the wrong side of full would never be served
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        st_req && !st_ack |-> !full
    );

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_req && !rd_ack |-> full
    );

endmodule

`default_nettype wire

// File: design/sram_ecc_top.sv
`default_nettype none

module sram_ecc_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // host write side
    input  logic                               wr_req,
    output logic                               wr_ack,
    input  logic [ecc_pkg::word_width-1:0]     wr_data,
    // error injection
    input  logic                               inj_req,
    output logic                               inj_ack,
    input  logic [ecc_pkg::word_idx_width-1:0] inj_word,
    input  logic [ecc_pkg::bit_idx_width-1:0]  inj_bit,
    // host read side
    output logic                               out_req,
    input  logic                               out_ack,
    output logic [ecc_pkg::word_width-1:0]     out_data,
    output logic [ecc_pkg::word_idx_width-1:0] out_index,
    output logic [ecc_pkg::status_width-1:0]   out_status
);

    import ecc_pkg::*;

    logic                      full;

    logic                      st_req;
    logic                      st_ack;
    logic [word_idx_width-1:0] st_addr;
    logic [word_width-1:0]     st_data;
    logic [code_width-1:0]     st_code;
    logic                      st_last;

    logic                      rd_req;
    logic                      rd_ack;
    logic [word_idx_width-1:0] rd_addr;
    logic                      rd_free;
    logic [word_width-1:0]     rd_data;
    logic [code_width-1:0]     rd_code;

    ////////////////////////////////////////////////////////////////////////////
    // encoder -> store -> decoder
    ////////////////////////////////////////////////////////////////////////////
    page_encoder encoder_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_ack  (wr_ack),
        .wr_data (wr_data),
        .full    (full),
        .st_req  (st_req),
        .st_ack  (st_ack),
        .st_addr (st_addr),
        .st_data (st_data),
        .st_code (st_code),
        .st_last (st_last)
    );

    page_store store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_req   (st_req),
        .st_ack   (st_ack),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .st_code  (st_code),
        .st_last  (st_last),
        .rd_req   (rd_req),
        .rd_ack   (rd_ack),
        .rd_addr  (rd_addr),
        .rd_free  (rd_free),
        .rd_data  (rd_data),
        .rd_code  (rd_code),
        .inj_req  (inj_req),
        .inj_ack  (inj_ack),
        .inj_word (inj_word),
        .inj_bit  (inj_bit),
        .full     (full)
    );

    page_decoder decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .full       (full),
        .rd_req     (rd_req),
        .rd_ack     (rd_ack),
        .rd_addr    (rd_addr),
        .rd_free    (rd_free),
        .rd_data    (rd_data),
        .rd_code    (rd_code),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data),
        .out_index  (out_index),
        .out_status (out_status)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile and run the SRAM ECC testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

if ! verilator --binary --assert --top-module tb_sram_ecc \
        -f sources.f --Mdir "$build_dir" -o sim_tb; then
    echo "verilator compile failed"
    exit 1
fi

output=$("./$build_dir/sim_tb")
sim_status=$?
printf '%s\n' "$output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1

// File: sources.f
design/ecc_pkg.sv
design/page_encoder.sv
design/page_store.sv
design/page_decoder.sv
design/sram_ecc_top.sv
verif/tb_sram_ecc.sv

// File: verif/tb_sram_ecc.sv
`default_nettype none

module tb_sram_ecc;

    import ecc_pkg::*;

    localparam int settle      = 1;
    localparam int wait_limit  = 400;

    logic                      clk;
    logic                      rst_n;
    logic                      wr_req;
    logic                      wr_ack;
    logic [word_width-1:0]     wr_data;
    logic                      inj_req;
    logic                      inj_ack;
    logic [word_idx_width-1:0] inj_word;
    logic [bit_idx_width-1:0]  inj_bit;
    logic                      out_req;
    logic                      out_ack;
    logic [word_width-1:0]     out_data;
    logic [word_idx_width-1:0] out_index;
    logic [status_width-1:0]   out_status;

    int    seed = 25;
    int    errors = 0;
    int    tests = 0;
    int    passed = 0;
    int    errors_at_start;
    string test_name = "reset";

    logic [word_width-1:0]     page_buf [page_words];
    logic [word_width-1:0]     recv_buf [page_words];
    logic [word_width-1:0]     exp_data_q [$];
    logic [status_width-1:0]   exp_status_q [$];
    logic [word_width-1:0]     exp_data;
    logic [status_width-1:0]   exp_status;
    logic [word_idx_width-1:0] exp_index = '0;
    logic                      exp_valid = 1'b0;
    logic [code_width-1:0]     exp_code = '0;
    int                        write_pos = 0;
    // pages fully written whose last word has not yet been offered
    int                        pages_unread = 0;
    bit                        slow_host = 1'b0;
    bit                        host_busy = 1'b0;

    sram_ecc_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_req     (wr_req),
        .wr_ack     (wr_ack),
        .wr_data    (wr_data),
        .inj_req    (inj_req),
        .inj_ack    (inj_ack),
        .inj_word   (inj_word),
        .inj_bit    (inj_bit),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data),
        .out_index  (out_index),
        .out_status (out_status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [code_width-1:0] page_code(
        input logic [word_width-1:0] pg [page_words]
    );
        logic [code_width-1:0] c;
        c = '0;
        for (int w = 0; w < page_words; w++) begin
            for (int b = 0; b < word_width; b++) begin
                if (pg[w][b]) begin
                    c[overall_bit] = ~c[overall_bit];
                    for (int k = 0; k < word_idx_width; k++) begin
                        if (w[k]) c[word_par_lsb + k] = ~c[word_par_lsb + k];
                    end
                    for (int j = 0; j < bit_idx_width; j++) begin
                        if (b[j]) c[bit_par_lsb + j] = ~c[bit_par_lsb + j];
                    end
                end
            end
        end
        return c;
    endfunction

    function automatic void refresh_head();
        exp_valid = exp_data_q.size() > 0;
        if (exp_valid) begin
            exp_data   = exp_data_q[0];
            exp_status = exp_status_q[0];
        end
    endfunction

    // recv_buf holds what the store will contain when the decoder reads it
    task automatic expect_page();
        logic [code_width-1:0]   syn;
        logic [status_width-1:0] st;
        logic [word_width-1:0]   fixed [page_words];
        fixed = recv_buf;
        syn = page_code(recv_buf) ^ page_code(page_buf);
        if (syn == '0) begin
            st = status_clean;
        end else if (syn[overall_bit]) begin
            st = status_corrected;
            fixed[syn[word_par_lsb +: word_idx_width]][syn[bit_par_lsb +: bit_idx_width]] ^= 1'b1;
        end else begin
            st = status_uncorrectable;
        end
        for (int i = 0; i < page_words; i++) begin
            exp_data_q.push_back(fixed[i]);
            exp_status_q.push_back(st);
        end
        refresh_head();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_out_expected: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> exp_valid)
        else begin
            $display("%s: output word %0d offered with no word expected", test_name, out_index);
            errors++;
        end

    a_out_match: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) && exp_valid |->
            (out_data == exp_data && out_index == exp_index && out_status == exp_status))
        else begin
            $display("error %s: expected word %0d data %h status %0d, got word %0d data %h status %0d",
                     test_name, exp_index, exp_data, exp_status, out_index, out_data, out_status);
            errors++;
        end

    a_code_match: assert property (@(posedge clk) disable iff (!rst_n)
        dut_i.st_req && dut_i.st_last |-> dut_i.st_code == exp_code)
        else begin
            $display("error %s: expected code %h, got %h", test_name, exp_code, dut_i.st_code);
            errors++;
        end

    a_hold_while_full: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wr_ack) && write_pos == 0 |-> pages_unread == 0)
        else begin
            $display("error %s: unread pages at first word ack expected 0, got %0d",
                     test_name, pages_unread);
            errors++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // handshake helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic timeout_fail(input string what);
        errors++;
        $display("%s: timed out waiting for %s", test_name, what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    function automatic logic probe(input string name);
        case (name)
            "wr_ack":  return wr_ack;
            "inj_ack": return inj_ack;
            "out_req": return out_req;
            default:   return 1'bx;
        endcase
    endfunction

    task automatic wait_level(input string name, input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (probe(name) !== level && n < wait_limit);
        if (probe(name) !== level) timeout_fail({name, " to reach its level"});
    endtask

    task automatic make_page();
        for (int i = 0; i < page_words; i++) begin
            page_buf[i] = word_width'($random(seed));
        end
        recv_buf = page_buf;
    endtask

    task automatic write_word(input int i);
        @(posedge clk);
        #settle;
        write_pos = i;
        wr_data   = page_buf[i];
        wr_req    = 1'b1;
        wait_level("wr_ack", 1'b1);
        if (i == page_words - 1) pages_unread++;
        #settle;
        wr_req = 1'b0;
        wait_level("wr_ack", 1'b0);
    endtask

    task automatic write_page();
        exp_code = page_code(page_buf);
        for (int i = 0; i < page_words; i++) begin
            write_word(i);
        end
    endtask

    task automatic inject_flip(input int w, input int b);
        @(posedge clk);
        #settle;
        inj_word = word_idx_width'(w);
        inj_bit  = bit_idx_width'(b);
        inj_req  = 1'b1;
        wait_level("inj_ack", 1'b1);
        #settle;
        inj_req = 1'b0;
        wait_level("inj_ack", 1'b0);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_data_q.size() != 0 || host_busy) && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_data_q.size() != 0 || host_busy) timeout_fail("the page to drain");
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errors_at_start) begin
            passed++;
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // host read side, acks each offered word and retires its expected entry
    initial begin : out_host
        int delay;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && out_req && !host_busy) begin
                host_busy = 1'b1;
                if (out_index == last_word) pages_unread--;
                #settle;
                delay = slow_host ? 2 + ($random(seed) & 7) : 0;
                repeat (delay) begin
                    @(posedge clk);
                    #settle;
                end
                out_ack = 1'b1;
                if (exp_data_q.size() > 0) begin
                    void'(exp_data_q.pop_front());
                    void'(exp_status_q.pop_front());
                    exp_index = exp_index + 1'b1;
                end
                refresh_head();
                wait_level("out_req", 1'b0);
                #settle;
                out_ack   = 1'b0;
                host_busy = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main
        int w1;
        int b1;
        int w2;
        int b2;
        rst_n    = 1'b0;
        wr_req   = 1'b0;
        wr_data  = '0;
        inj_req  = 1'b0;
        inj_word = '0;
        inj_bit  = '0;
        repeat (16) @(posedge clk);
        #settle;
        rst_n = 1'b1;

        begin_test("reset_clean");
        assert (!wr_ack && !out_req && !inj_ack) else begin
            $display("error %s: expected wr_ack/out_req/inj_ack 000, got %b%b%b",
                     test_name, wr_ack, out_req, inj_ack);
            errors++;
        end
        make_page();
        expect_page();
        write_page();
        wait_drained();
        end_test();

        // flips go to the upper words, which pass 1 reads after the injection
        begin_test("single_error");
        make_page();
        w1 = 4 + ($random(seed) & 3);
        b1 = $random(seed) & 15;
        recv_buf[w1][b1] = ~recv_buf[w1][b1];
        expect_page();
        write_page();
        inject_flip(w1, b1);
        wait_drained();
        end_test();

        begin_test("double_error");
        make_page();
        w1 = 4 + ($random(seed) & 3);
        b1 = $random(seed) & 15;
        w2 = 4 + ($random(seed) & 3);
        b2 = $random(seed) & 15;
        if (w1 == w2 && b1 == b2) b2 = b1 ^ 1;
        recv_buf[w1][b1] = ~recv_buf[w1][b1];
        recv_buf[w2][b2] = ~recv_buf[w2][b2];
        expect_page();
        write_page();
        inject_flip(w1, b1);
        inject_flip(w2, b2);
        wait_drained();
        end_test();

        begin_test("back_pressure");
        slow_host = 1'b1;
        make_page();
        expect_page();
        write_page();
        make_page();
        expect_page();
        write_page();
        wait_drained();
        slow_host = 1'b0;
        end_test();

        // the store is not full yet, so a flip into a written word must be dropped
        begin_test("idle_injection");
        make_page();
        expect_page();
        exp_code = page_code(page_buf);
        for (int i = 0; i < page_words - 1; i++) begin
            write_word(i);
        end
        inject_flip($random(seed) & 3, $random(seed) & 15);
        write_word(page_words - 1);
        wait_drained();
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
